// ==== floo_narrow_wide_router_cr.f ====
src/floo_pkg.sv
src/floo_narrow_wide_pkg.sv
src/floo_link_if.sv
src/floo_vc_input.sv
src/floo_sw_alloc.sv
src/floo_vc_output.sv
src/floo_vc_router.sv
src/floo_narrow_wide_router_cr.sv
verif/floo_router_properties.sv
verif/tb_floo_narrow_wide_router_cr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_floo_narrow_wide_router_cr \
  -f floo_narrow_wide_router_cr.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Test OK$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/floo_link_if.sv ====
`timescale 1ns/100ps

interface floo_link_if #(
  parameter type flit_t = logic
);

  import floo_pkg::*;

  // Forward path
  logic   valid;
  flit_t  flit;

  // Credit return path, one credit per cycle
  logic   credit_v;
  vc_id_t credit_id;

  modport sender (
    output valid,
    output flit,
    input  credit_v,
    input  credit_id
  );

  modport receiver (
    input  valid,
    input  flit,
    output credit_v,
    output credit_id
  );

endinterface

// ==== src/floo_narrow_wide_pkg.sv ====
package floo_narrow_wide_pkg;

  localparam int NarrowDataWidth = 32;
  localparam int WideDataWidth   = 64;

  // Destination tile and the VC the flit travels on
  typedef struct packed {
    floo_pkg::coord_t dst;
    floo_pkg::vc_id_t vc;
  } hdr_t;

  // Request channel flit
  typedef struct packed {
    hdr_t                       hdr;
    logic [NarrowDataWidth-1:0] payload;
  } narrow_flit_t;

  // Data channel flit
  typedef struct packed {
    hdr_t                     hdr;
    logic [WideDataWidth-1:0] payload;
  } wide_flit_t;

endpackage

// ==== src/floo_narrow_wide_router_cr.sv ====
`timescale 1ns/100ps

module floo_narrow_wide_router_cr #(
  parameter int                    NumVC     = floo_pkg::NumVCMax,
  parameter int                    VCDepth   = 2,
  parameter floo_pkg::route_algo_e RouteAlgo = floo_pkg::XYRouting
) (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  input  floo_pkg::coord_t                                        coord_i,

  input  logic                           [floo_pkg::NumPorts-1:0] narrow_valid_i,
  input  floo_narrow_wide_pkg::narrow_flit_t [floo_pkg::NumPorts-1:0] narrow_flit_i,
  input  logic                           [floo_pkg::NumPorts-1:0] narrow_credit_v_i,
  input  floo_pkg::vc_id_t               [floo_pkg::NumPorts-1:0] narrow_credit_id_i,
  output logic                           [floo_pkg::NumPorts-1:0] narrow_valid_o,
  output floo_narrow_wide_pkg::narrow_flit_t [floo_pkg::NumPorts-1:0] narrow_flit_o,
  output logic                           [floo_pkg::NumPorts-1:0] narrow_credit_v_o,
  output floo_pkg::vc_id_t               [floo_pkg::NumPorts-1:0] narrow_credit_id_o,

  input  logic                           [floo_pkg::NumPorts-1:0] wide_valid_i,
  input  floo_narrow_wide_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_i,
  input  logic                           [floo_pkg::NumPorts-1:0] wide_credit_v_i,
  input  floo_pkg::vc_id_t               [floo_pkg::NumPorts-1:0] wide_credit_id_i,
  output logic                           [floo_pkg::NumPorts-1:0] wide_valid_o,
  output floo_narrow_wide_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_o,
  output logic                           [floo_pkg::NumPorts-1:0] wide_credit_v_o,
  output floo_pkg::vc_id_t               [floo_pkg::NumPorts-1:0] wide_credit_id_o
);

  import floo_narrow_wide_pkg::*;

  // Request channel
  floo_vc_router #(
    .flit_t    (narrow_flit_t),
    .NumVC     (NumVC),
    .VCDepth   (VCDepth),
    .RouteAlgo (RouteAlgo)
  ) i_narrow_router (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .coord_i     (coord_i),
    .valid_i     (narrow_valid_i),
    .flit_i      (narrow_flit_i),
    .credit_v_o  (narrow_credit_v_o),
    .credit_id_o (narrow_credit_id_o),
    .valid_o     (narrow_valid_o),
    .flit_o      (narrow_flit_o),
    .credit_v_i  (narrow_credit_v_i),
    .credit_id_i (narrow_credit_id_i)
  );

  // Data channel, fully independent of the request channel
  floo_vc_router #(
    .flit_t    (wide_flit_t),
    .NumVC     (NumVC),
    .VCDepth   (VCDepth),
    .RouteAlgo (RouteAlgo)
  ) i_wide_router (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .coord_i     (coord_i),
    .valid_i     (wide_valid_i),
    .flit_i      (wide_flit_i),
    .credit_v_o  (wide_credit_v_o),
    .credit_id_o (wide_credit_id_o),
    .valid_o     (wide_valid_o),
    .flit_o      (wide_flit_o),
    .credit_v_i  (wide_credit_v_i),
    .credit_id_i (wide_credit_id_i)
  );

endmodule

// ==== src/floo_pkg.sv ====
package floo_pkg;

  // Router radix: four mesh directions plus one local port
  localparam int NumPorts = 5;

  // vc_id_t can address at most two VCs
  localparam int NumVCMax = 2;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  // Tile position in the mesh
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } coord_t;

  typedef logic [0:0] vc_id_t;

  // Only dimension-ordered routing is supported
  typedef enum logic [0:0] {
    XYRouting = 1'b0
  } route_algo_e;

endpackage

// ==== src/floo_sw_alloc.sv ====
`timescale 1ns/100ps

module floo_sw_alloc #(
  parameter type flit_t = logic,
  parameter int  NumVC  = 2
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic            [floo_pkg::NumPorts-1:0][NumVC-1:0] head_valid_i,
  input  floo_pkg::port_e [floo_pkg::NumPorts-1:0][NumVC-1:0] head_port_i,
  input  flit_t           [floo_pkg::NumPorts-1:0][NumVC-1:0] head_flit_i,
  input  logic            [floo_pkg::NumPorts-1:0][NumVC-1:0] out_credit_ok_i,
  output logic            [floo_pkg::NumPorts-1:0][NumVC-1:0] pop_o,
  output logic            [floo_pkg::NumPorts-1:0]            grant_valid_o,
  output flit_t           [floo_pkg::NumPorts-1:0]            grant_flit_o
);

  import floo_pkg::*;

  localparam int VcIdxW   = (NumVC > 1) ? $clog2(NumVC) : 1;
  localparam int PortIdxW = $clog2(NumPorts);

  logic  [NumPorts-1:0][NumVC-1:0]    elig;
  logic  [NumPorts-1:0]               in_req;
  logic  [NumPorts-1:0][VcIdxW-1:0]   in_vc;
  port_e [NumPorts-1:0]               in_port;
  logic  [NumPorts-1:0][NumPorts-1:0] out_req;
  logic  [NumPorts-1:0][PortIdxW-1:0] out_sel;

  // Round-robin state: next VC per input, next input per output
  logic  [NumPorts-1:0][VcIdxW-1:0]   in_ptr_q;
  logic  [NumPorts-1:0][PortIdxW-1:0] out_ptr_q;

  // First requester at or after ptr, among n candidates
  function automatic int rr_pick(input logic [NumPorts-1:0] req, input int ptr, input int n);
    int idx;
    int sel;
    sel = ptr;
    for (int k = NumPorts - 1; k >= 0; k--) begin
      idx = (ptr + k) % n;
      if ((k < n) && req[idx]) begin
        sel = idx;
      end
    end
    return sel;
  endfunction

  always_comb begin
    pop_o         = '0;
    grant_valid_o = '0;
    grant_flit_o  = '0;

    // Stage one: one VC per input, only if its target output has credit
    for (int i = 0; i < NumPorts; i++) begin
      for (int v = 0; v < NumVC; v++) begin
        elig[i][v] = head_valid_i[i][v] && out_credit_ok_i[head_port_i[i][v]][v];
      end
      in_req[i]  = |elig[i];
      in_vc[i]   = VcIdxW'(rr_pick(NumPorts'(elig[i]), int'(in_ptr_q[i]), NumVC));
      in_port[i] = head_port_i[i][in_vc[i]];
    end

    // Stage two: one input per output, then crossbar and pop
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        out_req[o][i] = in_req[i] && (in_port[i] == port_e'(o));
      end
      grant_valid_o[o] = |out_req[o];
      out_sel[o]       = PortIdxW'(rr_pick(out_req[o], int'(out_ptr_q[o]), NumPorts));
      if (grant_valid_o[o]) begin
        grant_flit_o[o]                     = head_flit_i[out_sel[o]][in_vc[out_sel[o]]];
        pop_o[out_sel[o]][in_vc[out_sel[o]]] = 1'b1;
      end
    end
  end

  // Winners move to the back of the queue
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_ptr_q  <= '0;
      out_ptr_q <= '0;
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (grant_valid_o[o]) begin
          out_ptr_q[o] <= (out_sel[o] == PortIdxW'(NumPorts - 1)) ? '0 : out_sel[o] + 1'b1;
          in_ptr_q[out_sel[o]] <= (in_vc[out_sel[o]] == VcIdxW'(NumVC - 1)) ?
                                  '0 : in_vc[out_sel[o]] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/floo_vc_input.sv ====
`timescale 1ns/100ps

module floo_vc_input #(
  parameter type                   flit_t    = floo_narrow_wide_pkg::narrow_flit_t,
  parameter int                    NumVC     = 2,
  parameter int                    VCDepth   = 2,
  parameter floo_pkg::route_algo_e RouteAlgo = floo_pkg::XYRouting
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  floo_pkg::coord_t            coord_i,
  floo_link_if.receiver               in_link,
  input  logic            [NumVC-1:0] pop_i,
  output flit_t           [NumVC-1:0] head_flit_o,
  output logic            [NumVC-1:0] head_valid_o,
  output floo_pkg::port_e [NumVC-1:0] head_port_o
);

  import floo_pkg::*;

  localparam int PtrW = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int CntW = $clog2(VCDepth + 1);

  flit_t                        mem_q [NumVC][VCDepth];
  logic [NumVC-1:0][PtrW-1:0]   wr_ptr_q;
  logic [NumVC-1:0][PtrW-1:0]   rd_ptr_q;
  logic [NumVC-1:0][CntW-1:0]   cnt_q;
  logic [NumVC-1:0]             push;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(VCDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Output port of a head flit, decided against this tile's position
  function automatic port_e route(input coord_t dst, input coord_t own);
    port_e port;
    port = Local;
    if (RouteAlgo == XYRouting) begin
      if (dst.x > own.x) begin
        port = East;
      end else if (dst.x < own.x) begin
        port = West;
      end else if (dst.y > own.y) begin
        port = North;
      end else if (dst.y < own.y) begin
        port = South;
      end
    end
    return port;
  endfunction

  // Incoming flit lands in the buffer of its own VC
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      push[v] = in_link.valid && (in_link.flit.hdr.vc == vc_id_t'(v));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        end
        if (pop_i[v]) begin
          rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        end
        cnt_q[v] <= cnt_q[v] + CntW'(push[v]) - CntW'(pop_i[v]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NumVC; v++) begin
      if (push[v]) begin
        mem_q[v][wr_ptr_q[v]] <= in_link.flit;
      end
    end
  end

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      head_valid_o[v] = (cnt_q[v] != '0);
      head_flit_o[v]  = mem_q[v][rd_ptr_q[v]];
      head_port_o[v]  = route(head_flit_o[v].hdr.dst, coord_i);
    end
  end

  // At most one VC pops per cycle, so a single credit goes back upstream
  always_comb begin
    in_link.credit_v  = |pop_i;
    in_link.credit_id = '0;
    for (int v = 0; v < NumVC; v++) begin
      if (pop_i[v]) begin
        in_link.credit_id = vc_id_t'(v);
      end
    end
  end

endmodule

// ==== src/floo_vc_output.sv ====
`timescale 1ns/100ps

module floo_vc_output #(
  parameter type flit_t  = floo_narrow_wide_pkg::narrow_flit_t,
  parameter int  NumVC   = 2,
  parameter int  VCDepth = 2
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             grant_valid_i,
  input  flit_t            grant_flit_i,
  output logic [NumVC-1:0] credit_ok_o,
  floo_link_if.sender      out_link
);

  import floo_pkg::*;

  localparam int CntW = $clog2(VCDepth + 1);

  logic                       valid_q;
  flit_t                      flit_q;
  logic [NumVC-1:0][CntW-1:0] credit_cnt_q;
  logic [NumVC-1:0]           send;
  logic [NumVC-1:0]           ret;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      send[v] = grant_valid_i && (grant_flit_i.hdr.vc == vc_id_t'(v));
      ret[v]  = out_link.credit_v && (out_link.credit_id == vc_id_t'(v));
    end
  end

  // Credits are spent when the grant is taken, not when the flit leaves
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      for (int v = 0; v < NumVC; v++) begin
        credit_cnt_q[v] <= CntW'(VCDepth);
      end
    end else begin
      valid_q <= grant_valid_i;
      for (int v = 0; v < NumVC; v++) begin
        credit_cnt_q[v] <= credit_cnt_q[v] - CntW'(send[v]) + CntW'(ret[v]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid_i) begin
      flit_q <= grant_flit_i;
    end
  end

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      credit_ok_o[v] = (credit_cnt_q[v] != '0);
    end
  end

  assign out_link.valid = valid_q;
  assign out_link.flit  = flit_q;

endmodule

// ==== src/floo_vc_router.sv ====
`timescale 1ns/100ps

module floo_vc_router #(
  parameter type                   flit_t    = floo_narrow_wide_pkg::narrow_flit_t,
  parameter int                    NumVC     = 2,
  parameter int                    VCDepth   = 2,
  parameter floo_pkg::route_algo_e RouteAlgo = floo_pkg::XYRouting
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  floo_pkg::coord_t                          coord_i,
  input  logic             [floo_pkg::NumPorts-1:0] valid_i,
  input  flit_t            [floo_pkg::NumPorts-1:0] flit_i,
  output logic             [floo_pkg::NumPorts-1:0] credit_v_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] credit_id_o,
  output logic             [floo_pkg::NumPorts-1:0] valid_o,
  output flit_t            [floo_pkg::NumPorts-1:0] flit_o,
  input  logic             [floo_pkg::NumPorts-1:0] credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] credit_id_i
);

  import floo_pkg::*;

  flit_t  [NumPorts-1:0][NumVC-1:0] head_flit;
  logic   [NumPorts-1:0][NumVC-1:0] head_valid;
  port_e  [NumPorts-1:0][NumVC-1:0] head_port;
  logic   [NumPorts-1:0][NumVC-1:0] pop;
  logic   [NumPorts-1:0][NumVC-1:0] out_credit_ok;
  logic   [NumPorts-1:0]            grant_valid;
  flit_t  [NumPorts-1:0]            grant_flit;
  logic   [NumPorts-1:0]            in_credit_v;
  vc_id_t [NumPorts-1:0]            in_credit_id;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    floo_link_if #(.flit_t(flit_t)) in_link ();
    floo_link_if #(.flit_t(flit_t)) out_link ();

    assign in_link.valid    = valid_i[p];
    assign in_link.flit     = flit_i[p];
    assign in_credit_v[p]   = in_link.credit_v;
    assign in_credit_id[p]  = in_link.credit_id;

    floo_vc_input #(
      .flit_t    (flit_t),
      .NumVC     (NumVC),
      .VCDepth   (VCDepth),
      .RouteAlgo (RouteAlgo)
    ) i_input (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .coord_i      (coord_i),
      .in_link      (in_link),
      .pop_i        (pop[p]),
      .head_flit_o  (head_flit[p]),
      .head_valid_o (head_valid[p]),
      .head_port_o  (head_port[p])
    );

    floo_vc_output #(
      .flit_t  (flit_t),
      .NumVC   (NumVC),
      .VCDepth (VCDepth)
    ) i_output (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .grant_valid_i (grant_valid[p]),
      .grant_flit_i  (grant_flit[p]),
      .credit_ok_o   (out_credit_ok[p]),
      .out_link      (out_link)
    );

    assign valid_o[p]         = out_link.valid;
    assign flit_o[p]          = out_link.flit;
    assign out_link.credit_v  = credit_v_i[p];
    assign out_link.credit_id = credit_id_i[p];
  end

  floo_sw_alloc #(
    .flit_t (flit_t),
    .NumVC  (NumVC)
  ) i_sw_alloc (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .head_valid_i    (head_valid),
    .head_port_i     (head_port),
    .head_flit_i     (head_flit),
    .out_credit_ok_i (out_credit_ok),
    .pop_o           (pop),
    .grant_valid_o   (grant_valid),
    .grant_flit_o    (grant_flit)
  );

  // Upstream credits line up with the departing flit's valid_o
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_v_o  <= '0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= in_credit_v;
      credit_id_o <= in_credit_id;
    end
  end

endmodule

// ==== verif/floo_router_properties.sv ====
`timescale 1ns/100ps

module floo_router_properties #(
  parameter int NumVC   = 2,
  parameter int VCDepth = 2,
  parameter int CntW    = 2
) (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic [NumVC-1:0]           send_i,
  input logic [NumVC-1:0][CntW-1:0] credit_cnt_i,
  input logic                       valid_i
);

  for (genvar v = 0; v < NumVC; v++) begin : gen_vc
    // A grant spends a credit that must exist
    send_needs_credit: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) send_i[v] |-> (credit_cnt_i[v] != '0)
    ) else $error("flit sent on VC %0d with no credit left", v);

    credit_bounded: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) credit_cnt_i[v] <= CntW'(VCDepth)
    ) else $error("credit counter of VC %0d above buffer depth", v);
  end

  valid_low_after_reset: assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> !valid_i
  ) else $error("output valid high in the first cycle after reset");

endmodule

bind floo_vc_output floo_router_properties #(
  .NumVC   (NumVC),
  .VCDepth (VCDepth),
  .CntW    (CntW)
) i_properties (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .send_i       (send),
  .credit_cnt_i (credit_cnt_q),
  .valid_i      (valid_q)
);

// ==== verif/tb_floo_narrow_wide_router_cr.sv ====
`timescale 1ns/100ps

module tb_floo_narrow_wide_router_cr;

  import floo_pkg::*;
  import floo_narrow_wide_pkg::*;

  localparam int VCDepth    = 2;
  localparam int NumEntries = 73;

  typedef struct {
    int     step;
    int     chan;
    int     src;
    int     vc;
    coord_t dst;
    port_e  exp;
    bit     lone;
  } entry_t;

  typedef struct {
    logic [70:0] flit;
    int          cyc;
    bit          lone;
  } exp_t;

  logic clk;
  logic arst_n;
  coord_t coord;
  logic [4:0] narrow_valid_i, narrow_credit_v_i, narrow_valid_o, narrow_credit_v_o;
  logic [4:0] wide_valid_i, wide_credit_v_i, wide_valid_o, wide_credit_v_o;
  narrow_flit_t [4:0] narrow_flit_i, narrow_flit_o;
  wide_flit_t [4:0] wide_flit_i, wide_flit_o;
  vc_id_t [4:0] narrow_credit_id_i, narrow_credit_id_o, wide_credit_id_i, wide_credit_id_o;

  entry_t tbl[NumEntries];
  exp_t exp_q[2][5][5][2][$];
  int credits[2][5][2];
  int pending[2][5][2];
  int rx_cnt[2][5][2];
  bit hold[2][5];
  int n, cyc, errors, sent_total, rx_total;
  int base_east[2];

  floo_narrow_wide_router_cr #(.VCDepth(VCDepth)) dut_i (
    .clk_i(clk), .arst_n_i(arst_n), .coord_i(coord),
    .narrow_valid_i(narrow_valid_i), .narrow_flit_i(narrow_flit_i),
    .narrow_credit_v_i(narrow_credit_v_i), .narrow_credit_id_i(narrow_credit_id_i),
    .narrow_valid_o(narrow_valid_o), .narrow_flit_o(narrow_flit_o),
    .narrow_credit_v_o(narrow_credit_v_o), .narrow_credit_id_o(narrow_credit_id_o),
    .wide_valid_i(wide_valid_i), .wide_flit_i(wide_flit_i),
    .wide_credit_v_i(wide_credit_v_i), .wide_credit_id_i(wide_credit_id_i),
    .wide_valid_o(wide_valid_o), .wide_flit_o(wide_flit_o),
    .wide_credit_v_o(wide_credit_v_o), .wide_credit_id_o(wide_credit_id_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // XY rule for a tile at (2,2)
  function automatic port_e expected_port(input coord_t d);
    if (d.x > 3'd2) return East;
    else if (d.x < 3'd2) return West;
    else if (d.y > 3'd2) return North;
    else if (d.y < 3'd2) return South;
    return Local;
  endfunction

  function automatic string chname(input int c);
    return (c == 0) ? "narrow" : "wide";
  endfunction

  function automatic logic [70:0] out_flit(input int c, input int p);
    return (c == 0) ? 71'(narrow_flit_o[p]) : 71'(wide_flit_o[p]);
  endfunction

  task automatic add_entry(input int step, input int chan, input int src, input int vc,
                           input int x, input int y, input bit lone);
    tbl[n].step = step;
    tbl[n].chan = chan;
    tbl[n].src = src;
    tbl[n].vc = vc;
    tbl[n].dst.x = 3'(x);
    tbl[n].dst.y = 3'(y);
    tbl[n].exp = expected_port(tbl[n].dst);
    tbl[n].lone = lone;
    n++;
  endtask

  task automatic drive_entry(input entry_t e);
    logic [63:0] pl;
    narrow_flit_t nf;
    wide_flit_t wf;
    exp_t x;
    pl = {$urandom, $urandom};
    x.cyc = cyc;
    x.lone = e.lone;
    if (e.chan != 1) begin
      nf.hdr.dst = e.dst;
      nf.hdr.vc = vc_id_t'(e.vc);
      nf.payload = {pl[31:3], 3'(e.src)};
      narrow_valid_i[e.src] = 1'b1;
      narrow_flit_i[e.src] = nf;
      x.flit = 71'(nf);
      exp_q[0][e.exp][e.src][e.vc].push_back(x);
      credits[0][e.src][e.vc]--;
      sent_total++;
    end
    if (e.chan != 0) begin
      wf.hdr.dst = e.dst;
      wf.hdr.vc = vc_id_t'(e.vc);
      wf.payload = {pl[63:3], 3'(e.src)};
      wide_valid_i[e.src] = 1'b1;
      wide_flit_i[e.src] = wf;
      x.flit = 71'(wf);
      exp_q[1][e.exp][e.src][e.vc].push_back(x);
      credits[1][e.src][e.vc]--;
      sent_total++;
    end
  endtask

  // Entries of one step go out together once every one of them holds a credit
  task automatic send_step(input int first, input int last);
    bit ok;
    ok = 1'b0;
    while (!ok) begin
      ok = 1'b1;
      for (int k = first; k < last; k++) begin
        if (tbl[k].chan != 1 && credits[0][tbl[k].src][tbl[k].vc] == 0) ok = 1'b0;
        if (tbl[k].chan != 0 && credits[1][tbl[k].src][tbl[k].vc] == 0) ok = 1'b0;
      end
      if (!ok) begin
        @(posedge clk);
        #2;
      end
    end
    for (int k = first; k < last; k++) drive_entry(tbl[k]);
    @(posedge clk);
    #2;
    narrow_valid_i = '0;
    wide_valid_i = '0;
  endtask

  task automatic apply_steps(input int lo, input int hi);
    int i;
    int j;
    i = lo;
    while (i < hi) begin
      j = i;
      while (j < hi && tbl[j].step == tbl[i].step) j++;
      send_step(i, j);
      i = j;
    end
  endtask

  task automatic wait_drain();
    while (sent_total != rx_total) @(posedge clk);
    repeat (6) @(posedge clk);
    #2;
  endtask

  task automatic check_idle();
    if (narrow_valid_o != '0) begin
      errors++;
      $display("Error: narrow_valid_o = %h, expected %h", narrow_valid_o, 5'h0);
    end
    if (narrow_credit_v_o != '0) begin
      errors++;
      $display("Error: narrow_credit_v_o = %h, expected %h", narrow_credit_v_o, 5'h0);
    end
    if (wide_valid_o != '0) begin
      errors++;
      $display("Error: wide_valid_o = %h, expected %h", wide_valid_o, 5'h0);
    end
    if (wide_credit_v_o != '0) begin
      errors++;
      $display("Error: wide_credit_v_o = %h, expected %h", wide_credit_v_o, 5'h0);
    end
  endtask

  task automatic check_flit(input int c, input int p, input logic [70:0] f);
    int src;
    int vc;
    exp_t x;
    logic rv;
    vc_id_t rid;
    src = int'(f[2:0]);
    vc = (c == 0) ? int'(f[32]) : int'(f[64]);
    rx_total++;
    rx_cnt[c][p][vc]++;
    pending[c][p][vc]++;
    if (src > 4 || exp_q[c][p][src][vc].size() == 0) begin
      errors++;
      $display("Unexpected flit on %s port %0d, vc %0d: %h", chname(c), p, vc, f);
    end else begin
      x = exp_q[c][p][src][vc].pop_front();
      if (f != x.flit) begin
        errors++;
        $display("Error: %s_flit_o[%0d] = %h, expected %h", chname(c), p, f, x.flit);
      end
      if (x.lone) begin
        rv = (c == 0) ? narrow_credit_v_o[src] : wide_credit_v_o[src];
        rid = (c == 0) ? narrow_credit_id_o[src] : wide_credit_id_o[src];
        if (cyc - x.cyc != 2) begin
          errors++;
          $display("Error: %s latency on port %0d = %h, expected %h", chname(c), p,
                   cyc - x.cyc, 2);
        end
        if (!rv || rid != vc_id_t'(vc)) begin
          errors++;
          $display("Error: %s_credit_v_o[%0d] = %h, credit_id_o = %h, expected 1 and %h",
                   chname(c), src, rv, rid, vc);
        end
      end
    end
  endtask

  // Monitor samples at the falling edge, away from the drive time
  always @(negedge clk) begin
    if (arst_n) begin
      for (int c = 0; c < 2; c++) begin
        for (int p = 0; p < 5; p++) begin
          if ((c == 0) ? narrow_credit_v_o[p] : wide_credit_v_o[p]) begin
            vc_id_t id;
            id = (c == 0) ? narrow_credit_id_o[p] : wide_credit_id_o[p];
            credits[c][p][id]++;
            if (credits[c][p][id] > VCDepth) begin
              errors++;
              $display("Credit returned on %s port %0d vc %0d with no flit outstanding",
                       chname(c), p, id);
            end
          end
          if ((c == 0) ? narrow_valid_o[p] : wide_valid_o[p]) check_flit(c, p, out_flit(c, p));
        end
      end
    end
  end

  // Downstream model returns one credit per cycle and port unless held
  always @(posedge clk) begin
    #2;
    narrow_credit_v_i = '0;
    wide_credit_v_i = '0;
    for (int c = 0; c < 2; c++) begin
      for (int p = 0; p < 5; p++) begin
        for (int v = 0; v < 2; v++) begin
          if (!hold[c][p] && pending[c][p][v] > 0) begin
            pending[c][p][v]--;
            if (c == 0) begin
              narrow_credit_v_i[p] = 1'b1;
              narrow_credit_id_i[p] = vc_id_t'(v);
            end else begin
              wide_credit_v_i[p] = 1'b1;
              wide_credit_id_i[p] = vc_id_t'(v);
            end
            break;
          end
        end
      end
    end
  end

  initial begin
    #((NumEntries * 40 + 16) * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int dx[8];
    int dy[8];
    dx = '{2, 4, 2, 0, 2, 3, 1, 4};
    dy = '{4, 2, 0, 2, 2, 1, 3, 4};
    void'($urandom(32'h8ec1));
    arst_n = 1'b0;
    coord.x = 3'd2;
    coord.y = 3'd2;
    narrow_valid_i = '0;
    narrow_flit_i = '0;
    narrow_credit_v_i = '0;
    narrow_credit_id_i = '0;
    wide_valid_i = '0;
    wide_flit_i = '0;
    wide_credit_v_i = '0;
    wide_credit_id_i = '0;
    n = 0;
    cyc = 0;
    errors = 0;
    sent_total = 0;
    rx_total = 0;
    for (int c = 0; c < 2; c++) begin
      for (int p = 0; p < 5; p++) begin
        hold[c][p] = 1'b0;
        for (int v = 0; v < 2; v++) begin
          credits[c][p][v] = VCDepth;
          pending[c][p][v] = 0;
          rx_cnt[c][p][v] = 0;
        end
      end
    end

    // Lone flits from every input in every direction, even rows on both channels
    for (int s = 0; s < 5; s++) begin
      for (int d = 0; d < 8; d++) begin
        add_entry(n, (d % 2 == 0) ? 2 : 0, s, (s + d) % 2, dx[d], dy[d], 1);
      end
    end
    // All inputs toward Local at once
    for (int r = 0; r < 3; r++) begin
      for (int s = 0; s < 5; s++) add_entry(100 + r, 2, s, (s + r) % 2, 2, 2, 0);
    end
    // North and South toward East while West keeps feeding Local
    for (int r = 0; r < 6; r++) begin
      add_entry(200 + r, 0, North, (r < 3) ? 0 : 1, 4, 2, 0);
      add_entry(200 + r, 0, South, (r < 3) ? 1 : 0, 4, 2, 0);
      add_entry(200 + r, 0, West, r % 2, 2, 2, 0);
    end

    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #2;

    for (int i = 0; i < 40; i++) begin
      apply_steps(i, i + 1);
      wait_drain();
    end
    apply_steps(40, 55);
    wait_drain();

    base_east[0] = rx_cnt[0][East][0];
    base_east[1] = rx_cnt[0][East][1];
    hold[0][East] = 1'b1;
    fork
      apply_steps(55, n);
      begin
        int stuck;
        repeat (30) @(posedge clk);
        #2;
        for (int v = 0; v < 2; v++) begin
          if (rx_cnt[0][East][v] - base_east[v] > VCDepth) begin
            errors++;
            $display("Error: narrow East vc %0d flits under back-pressure = %h, limit %h",
                     v, rx_cnt[0][East][v] - base_east[v], VCDepth);
          end
        end
        // Every flit already sent toward Local must be out by now
        stuck = 0;
        for (int s = 0; s < 5; s++) begin
          for (int v = 0; v < 2; v++) begin
            stuck += exp_q[0][Local][s][v].size();
          end
        end
        if (stuck != 0) begin
          errors++;
          $display("Traffic to the Local port stalled while East was held");
        end
        hold[0][East] = 1'b0;
      end
    join
    wait_drain();

    for (int c = 0; c < 2; c++) begin
      for (int p = 0; p < 5; p++) begin
        for (int v = 0; v < 2; v++) begin
          if (credits[c][p][v] != VCDepth) begin
            errors++;
            $display("Error: %s input credits port %0d vc %0d = %h, expected %h",
                     chname(c), p, v, credits[c][p][v], VCDepth);
          end
        end
      end
    end

    $display("Run complete: %0d flits sent, %0d received, %0d errors",
             sent_total, rx_total, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
